/* Makefile */
TOP = tb_if_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f if_stage.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

/* compressed_decoder.sv */
`timescale 1ns/100ps

module compressed_decoder import rvc_pkg::*; (
  input  logic [INSTR_W-1:0] instr_i,
  output logic [INSTR_W-1:0] instr_o,
  output logic               is_compressed_o,
  output logic               illegal_instr_o,
  output rvc_op_e            c_op_o
);

  logic [CINSTR_W-1:0] c;
  logic [4:0]          rd_rs1;
  logic [4:0]          rs2;
  // Primed registers of the CL/CS formats
  logic [4:0]          rs1_p;
  logic [4:0]          rd_p;
  logic [11:0]         imm6_sext;

  assign c         = instr_i[CINSTR_W-1:0];
  assign rd_rs1    = c[11:7];
  assign rs2       = c[6:2];
  assign rs1_p     = {RVC_REG_PFX, c[9:7]};
  assign rd_p      = {RVC_REG_PFX, c[4:2]};
  assign imm6_sext = {{6{c[12]}}, c[12], c[6:2]};

  assign is_compressed_o = c[1:0] != 2'b11;

  ////////////////////
  // Classify
  ////////////////////

  always_comb begin
    c_op_o = C_ILLEGAL;
    case (c[1:0])
      RVC_Q0: begin
        if (c[15:13] == 3'b010) c_op_o = C_LW;
        if (c[15:13] == 3'b110) c_op_o = C_SW;
      end
      RVC_Q1: begin
        if (c[15:13] == 3'b000) c_op_o = C_ADDI;
        if (c[15:13] == 3'b010) c_op_o = C_LI;
        if (c[15:13] == 3'b101) c_op_o = C_J;
      end
      RVC_Q2: begin
        // rs2 of zero would be C.JR or C.JALR
        if (c[15:13] == 3'b100 && rs2 != 5'd0) begin
          c_op_o = c[12] ? C_ADD : C_MV;
        end
      end
      // Full-width instructions report C_ILLEGAL but are not flagged
      default: ;
    endcase
  end

  ////////////////////
  // Expand
  ////////////////////

  always_comb begin
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;
    if (is_compressed_o) begin
      case (c_op_o)
        C_ADDI: instr_o = {imm6_sext, rd_rs1, F3_ADD, rd_rs1, OPC_OP_IMM};
        C_LI:   instr_o = {imm6_sext, 5'd0, F3_ADD, rd_rs1, OPC_OP_IMM};
        // Word offset scaled by four, zero extended
        C_LW:   instr_o = {5'd0, c[5], c[12:10], c[6], 2'b00, rs1_p, F3_WORD, rd_p, OPC_LOAD};
        C_SW:   instr_o = {5'd0, c[5], c[12], rd_p, rs1_p, F3_WORD,
                           c[11:10], c[6], 2'b00, OPC_STORE};
        // jal x0 with the scrambled 12-bit offset sign extended
        C_J:    instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, 5'd0, OPC_JAL};
        C_MV:   instr_o = {7'd0, rs2, 5'd0, F3_ADD, rd_rs1, OPC_OP};
        C_ADD:  instr_o = {7'd0, rs2, rd_rs1, F3_ADD, rd_rs1, OPC_OP};
        // Original bits go on to ID for the illegal-instruction trap
        default: illegal_instr_o = 1'b1;
      endcase
    end
  end

endmodule

/* fetch_addr_sel.sv */
`timescale 1ns/100ps

module fetch_addr_sel import if_ctrl_pkg::*; (
  input  pc_mux_e             pc_mux_i,
  input  logic [ADDR_W-1:0]   boot_addr_i,
  input  logic [ADDR_W-1:0]   jump_target_i,
  input  logic [ADDR_W-1:0]   branch_target_i,
  input  logic [ADDR_W-1:0]   mepc_i,
  input  logic [ADDR_W-1:0]   dpc_i,
  input  logic [ADDR_W-1:0]   dm_halt_addr_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  output logic [ADDR_W-1:0]   branch_addr_o
);

  logic [ADDR_W-1:0] addr_sel;

  always_comb begin
    // Boot address unless a known source is selected
    addr_sel = {boot_addr_i[ADDR_W-1:WORD_ALIGN_W], {WORD_ALIGN_W{1'b0}}};
    case (pc_mux_i)
      PC_JUMP:     addr_sel = jump_target_i;
      PC_BRANCH:   addr_sel = branch_target_i;
      // Return from trap or debug restores the saved PC
      PC_MRET:     addr_sel = mepc_i;
      PC_DRET:     addr_sel = dpc_i;
      // All exceptions share the base vector
      PC_TRAP_EXC: addr_sel = {mtvec_addr_i, EXC_VEC_OFFSET};
      // Vectored mode, one word per interrupt line
      PC_TRAP_IRQ: addr_sel = {mtvec_addr_i, irq_id_i, {IRQ_PAD_W{1'b0}}};
      PC_TRAP_DBD: addr_sel = {dm_halt_addr_i[ADDR_W-1:WORD_ALIGN_W], {WORD_ALIGN_W{1'b0}}};
      default:     ;
    endcase
  end

  // Instructions are at least halfword aligned
  assign branch_addr_o = {addr_sel[ADDR_W-1:1], 1'b0};

endmodule

/* if_ctrl_pkg.sv */
package if_ctrl_pkg;

  ////////////////////
  // Address widths
  ////////////////////

  localparam int ADDR_W   = 32;
  // Base field of mtvec, upper bits of every trap vector
  localparam int MTVEC_W  = 25;
  localparam int IRQ_ID_W = 5;

  // Low bits cleared for word alignment
  localparam int WORD_ALIGN_W = 2;

  ////////////////////
  // Vector constants
  ////////////////////

  // Exceptions land on mtvec base with seven zero bits below
  localparam int                      EXC_OFFSET_W   = ADDR_W - MTVEC_W;
  localparam logic [EXC_OFFSET_W-1:0] EXC_VEC_OFFSET = '0;
  // Interrupt index sits above two zero bits
  localparam int IRQ_PAD_W = EXC_OFFSET_W - IRQ_ID_W;

  ////////////////////
  // Fetch queue sizing
  ////////////////////

  localparam int MAX_OUTSTND   = 2;
  localparam int OUTSTND_CNT_W = $clog2(MAX_OUTSTND + 1);
  localparam int FIFO_DEPTH    = 3;
  // Counter holds 0 up to FIFO_DEPTH
  localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);

  // Redirect sources
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_DBD = 4'd7
  } pc_mux_e;

endpackage

/* if_stage.f */
if_ctrl_pkg.sv
rvc_pkg.sv
fetch_addr_sel.sv
prefetch_unit.sv
compressed_decoder.sv
if_stage.sv
tb_instr_mem.sv
tb_if_stage.sv

/* if_stage.sv */
`timescale 1ns/100ps

module if_stage import if_ctrl_pkg::*, rvc_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // Redirect control
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  logic                kill_if_i,
  input  logic                halt_if_i,
  input  logic [ADDR_W-1:0]   boot_addr_i,
  input  logic [ADDR_W-1:0]   jump_target_i,
  input  logic [ADDR_W-1:0]   branch_target_i,
  input  logic [ADDR_W-1:0]   mepc_i,
  input  logic [ADDR_W-1:0]   dpc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic [ADDR_W-1:0]   dm_halt_addr_i,
  // OBI instruction bus
  output logic                instr_req_o,
  output logic [ADDR_W-1:0]   instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [INSTR_W-1:0]  instr_rdata_i,
  input  logic                instr_err_i,
  // Status
  output logic                csr_mtvec_init_o,
  output logic                if_busy_o,
  output logic [ADDR_W-1:0]   pc_if_o,
  // IF/ID register
  output logic                id_valid_o,
  input  logic                id_ready_i,
  output logic [INSTR_W-1:0]  id_instr_o,
  output logic [ADDR_W-1:0]   id_pc_o,
  output logic                id_compressed_o,
  output logic [CINSTR_W-1:0] id_compressed_instr_o,
  output logic                id_illegal_c_o,
  output logic                id_bus_err_o
);

  logic [ADDR_W-1:0]  branch_addr;
  logic               fetch_valid;
  logic               fetch_ready;
  logic [INSTR_W-1:0] fetch_instr;
  logic [ADDR_W-1:0]  fetch_pc;
  logic               fetch_err;
  logic [INSTR_W-1:0] dec_instr;
  logic               dec_compressed;
  logic               dec_illegal;
  logic               if_valid;

  fetch_addr_sel fetch_addr_sel_i (
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .dpc_i           (dpc_i),
    .dm_halt_addr_i  (dm_halt_addr_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_id_i        (irq_id_i),
    .branch_addr_o   (branch_addr)
  );

  prefetch_unit prefetch_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_instr_o  (fetch_instr),
    .fetch_pc_o     (fetch_pc),
    .fetch_err_o    (fetch_err),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  compressed_decoder compressed_decoder_i (
    .instr_i         (fetch_instr),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_instr_o (dec_illegal),
    .c_op_o          ()
  );

  // mtvec gets its reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);
  assign pc_if_o          = fetch_pc;

  // Killed IF drains the buffer, halted IF holds it
  assign if_valid    = fetch_valid && !kill_if_i && !halt_if_i;
  assign fetch_ready = kill_if_i || (!halt_if_i && id_ready_i);

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (id_ready_i) begin
      id_valid_o <= if_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid && id_ready_i) begin
      id_instr_o      <= dec_instr;
      id_pc_o         <= fetch_pc;
      id_compressed_o <= dec_compressed;
      id_illegal_c_o  <= dec_illegal;
      id_bus_err_o    <= fetch_err;
      // Keeps the last compressed halfword across 32-bit instructions
      if (dec_compressed) id_compressed_instr_o <= fetch_instr[CINSTR_W-1:0];
    end
  end

  a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i |=> $stable(id_instr_o) && $stable(id_pc_o));

endmodule

/* prefetch_unit.sv */
`timescale 1ns/100ps

module prefetch_unit import if_ctrl_pkg::*, rvc_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pc_set_i,
  input  logic [ADDR_W-1:0]  branch_addr_i,
  input  logic               fetch_ready_i,
  output logic               fetch_valid_o,
  output logic [INSTR_W-1:0] fetch_instr_o,
  output logic [ADDR_W-1:0]  fetch_pc_o,
  output logic               fetch_err_o,
  output logic               busy_o,
  output logic               instr_req_o,
  output logic [ADDR_W-1:0]  instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               instr_err_i
);

  logic                     fetching_q;
  logic [ADDR_W-1:0]        req_addr_q;
  logic [OUTSTND_CNT_W-1:0] outstnd_cnt_q;
  logic [OUTSTND_CNT_W-1:0] outstnd_cnt_d;
  // Responses still owed to a stream that was redirected away
  logic [OUTSTND_CNT_W-1:0] discard_cnt_q;
  logic [INSTR_W-1:0]       buf_data_q [FIFO_DEPTH];
  logic                     buf_err_q  [FIFO_DEPTH];
  logic [FIFO_CNT_W-1:0]    cnt_q;
  logic [FIFO_CNT_W-1:0]    wr_idx;
  logic [ADDR_W-1:0]        pc_q;
  logic                     bus_ack;
  logic                     push;
  logic                     pop;
  logic                     consume;
  logic                     is_comp;
  logic [CINSTR_W-1:0]      hw_lo;
  logic [CINSTR_W-1:0]      hw_hi;

  ////////////////////
  // Bus request side
  ////////////////////

  // Room is needed for every word already requested
  assign instr_req_o  = fetching_q && (outstnd_cnt_q < MAX_OUTSTND) &&
                        (int'(cnt_q) + int'(outstnd_cnt_q) < FIFO_DEPTH);
  assign instr_addr_o = req_addr_q;
  assign bus_ack      = instr_req_o && instr_gnt_i;
  assign busy_o       = outstnd_cnt_q != '0;

  always_comb begin
    outstnd_cnt_d = outstnd_cnt_q;
    if (bus_ack) outstnd_cnt_d = outstnd_cnt_d + 1'b1;
    if (instr_rvalid_i) outstnd_cnt_d = outstnd_cnt_d - 1'b1;
  end

  ////////////////////
  // Word buffer and realignment
  ////////////////////

  // pc_q[1] is the halfword offset into the oldest word
  always_comb begin
    if (pc_q[1]) begin
      hw_lo = buf_data_q[0][INSTR_W-1:CINSTR_W];
      hw_hi = buf_data_q[1][CINSTR_W-1:0];
    end else begin
      hw_lo = buf_data_q[0][CINSTR_W-1:0];
      hw_hi = buf_data_q[0][INSTR_W-1:CINSTR_W];
    end
  end

  assign is_comp = hw_lo[1:0] != 2'b11;
  // A crossing 32-bit instruction waits for the second word
  assign fetch_valid_o = (cnt_q != '0) && (is_comp || !pc_q[1] || cnt_q >= FIFO_CNT_W'(2));
  assign fetch_instr_o = is_comp ? {{(INSTR_W - CINSTR_W){1'b0}}, hw_lo} : {hw_hi, hw_lo};
  assign fetch_err_o   = buf_err_q[0] || (pc_q[1] && !is_comp && buf_err_q[1]);
  assign fetch_pc_o    = pc_q;

  assign consume = fetch_valid_o && fetch_ready_i && !pc_set_i;
  // Head word retires once its upper half is used
  assign pop     = consume && (pc_q[1] || !is_comp);
  assign push    = instr_rvalid_i && (discard_cnt_q == '0) && !pc_set_i;
  assign wr_idx  = cnt_q - FIFO_CNT_W'(pop);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetching_q    <= 1'b0;
      req_addr_q    <= '0;
      outstnd_cnt_q <= '0;
      discard_cnt_q <= '0;
      cnt_q         <= '0;
      pc_q          <= '0;
    end else begin
      outstnd_cnt_q <= outstnd_cnt_d;
      if (pc_set_i) begin
        fetching_q    <= 1'b1;
        req_addr_q    <= {branch_addr_i[ADDR_W-1:WORD_ALIGN_W], {WORD_ALIGN_W{1'b0}}};
        pc_q          <= branch_addr_i;
        cnt_q         <= '0;
        // Everything still in flight belongs to the old stream
        discard_cnt_q <= outstnd_cnt_d;
      end else begin
        if (bus_ack) req_addr_q <= req_addr_q + ADDR_W'(4);
        if (consume) pc_q <= pc_q + (is_comp ? ADDR_W'(2) : ADDR_W'(4));
        cnt_q <= cnt_q + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);
        if (instr_rvalid_i && discard_cnt_q != '0) discard_cnt_q <= discard_cnt_q - 1'b1;
      end
    end
  end

  // Shift towards entry 0 on pop, then write behind the last valid entry
  always_ff @(posedge clk) begin
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        buf_data_q[i] <= buf_data_q[i+1];
        buf_err_q[i]  <= buf_err_q[i+1];
      end
    end
    if (push) begin
      buf_data_q[wr_idx] <= instr_rdata_i;
      buf_err_q[wr_idx]  <= instr_err_i;
    end
  end

  a_outstnd_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstnd_cnt_q <= MAX_OUTSTND);

  // Pending request keeps its address until granted, redirect aside
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i && !pc_set_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

/* rvc_pkg.sv */
package rvc_pkg;

  ////////////////////
  // Instruction widths
  ////////////////////

  localparam int INSTR_W  = 32;
  localparam int CINSTR_W = 16;

  // Compressed quadrants, low two bits
  localparam logic [1:0] RVC_Q0 = 2'b00;
  localparam logic [1:0] RVC_Q1 = 2'b01;
  localparam logic [1:0] RVC_Q2 = 2'b10;

  // Three-bit register fields map onto x8..x15
  localparam logic [1:0] RVC_REG_PFX = 2'b01;

  ////////////////////
  // Base ISA encodings
  ////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 for add/addi and for word load/store
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  // Kept compressed opcodes, everything else is illegal
  typedef enum logic [2:0] {
    C_ADDI, C_LI, C_LW, C_SW, C_J, C_MV, C_ADD, C_ILLEGAL
  } rvc_op_e;

endpackage

/* tb_if_stage.sv */
`timescale 1ns/100ps

module tb_if_stage import if_ctrl_pkg::*, rvc_pkg::*; ();

  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] ERR_ADDR   = 32'h0000_0600;
  // Cycles allowed for one instruction to reach ID
  localparam int          WAIT_LIMIT = 40;
  // Cycle budget per test, summed for the watchdog
  localparam int BOOT_CYC  = 200;
  localparam int REDIR_CYC = 500;
  localparam int COMP_CYC  = 200;
  localparam int BP_CYC    = 250;
  localparam int HALT_CYC  = 200;
  localparam int TOTAL_CYC = BOOT_CYC + REDIR_CYC + COMP_CYC + BP_CYC + HALT_CYC;

  logic clk = 1'b0;
  logic rst_n;
  logic pc_set_i, kill_if_i, halt_if_i, id_ready_i;
  pc_mux_e pc_mux_i;
  logic [31:0] boot_addr_i, jump_target_i, branch_target_i, mepc_i, dpc_i, dm_halt_addr_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        csr_mtvec_init_o, if_busy_o;
  logic [31:0] pc_if_o;
  logic        id_valid_o, id_compressed_o, id_illegal_c_o, id_bus_err_o;
  logic [31:0] id_instr_o, id_pc_o;
  logic [15:0] id_compressed_instr_o;

  // Last instruction taken by ID
  logic [31:0] cap_pc, cap_instr;
  logic [15:0] cap_chw;
  logic        cap_comp, cap_ill, cap_err;
  int          checks = 0;
  int          errors = 0;
  integer      seed = 73;
  // Requests granted on the bus and not yet answered
  int          bus_outstnd = 0;

  if_stage dut0 (.*);

  tb_instr_mem #(.ERR_ADDR(ERR_ADDR)) mem0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(TOTAL_CYC * CLK_PERIOD + 2000);
    $display("%0t: watchdog expired before the tests finished", $time);
    $display("Regression failed");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Busy follows the bus traffic, counted from grants and responses
  always @(posedge clk) begin
    if (rst_n) begin
      check_val("if_busy_o", 32'(if_busy_o), 32'(bus_outstnd != 0));
      bus_outstnd <= bus_outstnd + ((instr_req_o && instr_gnt_i) ? 1 : 0) -
                     (instr_rvalid_i ? 1 : 0);
    end
  end

  // Waits for the next transfer into ID, values sampled at the clock edge
  task automatic wait_instr(output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      if (id_valid_o && id_ready_i) begin
        ok        = 1'b1;
        cap_pc    = id_pc_o;
        cap_instr = id_instr_o;
        cap_chw   = id_compressed_instr_o;
        cap_comp  = id_compressed_o;
        cap_ill   = id_illegal_c_o;
        cap_err   = id_bus_err_o;
      end
      n++;
    end
    if (!ok) begin
      $display("%0t: no instruction reached ID within %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  // Target address from the redirect rules
  function automatic logic [31:0] expected_target(input pc_mux_e mux);
    logic [31:0] a;
    case (mux)
      PC_JUMP:     a = jump_target_i;
      PC_BRANCH:   a = branch_target_i;
      PC_MRET:     a = mepc_i;
      PC_DRET:     a = dpc_i;
      PC_TRAP_EXC: a = {mtvec_addr_i, 7'b0};
      PC_TRAP_IRQ: a = {mtvec_addr_i, irq_id_i, 2'b00};
      PC_TRAP_DBD: a = dm_halt_addr_i & 32'hFFFF_FFFC;
      default:     a = boot_addr_i & 32'hFFFF_FFFC;
    endcase
    return a & 32'hFFFF_FFFE;
  endfunction

  // Kill goes with the strobe so nothing old enters ID
  task automatic redirect(input pc_mux_e mux);
    logic [31:0] target;
    @(posedge clk);
    pc_set_i  <= 1'b1;
    pc_mux_i  <= mux;
    kill_if_i <= 1'b1;
    @(posedge clk);
    check_val("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(mux == PC_BOOT));
    pc_set_i  <= 1'b0;
    kill_if_i <= 1'b0;
    // New stream requests its first word in the cycle after the strobe
    @(posedge clk);
    target = expected_target(mux);
    check_val("instr_req_o", 32'(instr_req_o), 32'd1);
    check_val("instr_addr_o", instr_addr_o, target & 32'hFFFF_FFFC);
    check_val("pc_if_o", pc_if_o, target);
  endtask

  // Sequential 32-bit words straight from the memory image
  task automatic check_words(input logic [31:0] start, input int n);
    logic        ok;
    logic [31:0] pc;
    pc = start;
    for (int k = 0; k < n; k++) begin
      wait_instr(ok);
      if (!ok) return;
      check_val("id_pc_o", cap_pc, pc);
      check_val("id_instr_o", cap_instr, mem0.mem[pc[11:2]]);
      check_val("id_bus_err_o", 32'(cap_err), 32'(pc == ERR_ADDR));
      check_val("id_compressed_o", 32'(cap_comp), 32'd0);
      pc = pc + 32'd4;
    end
  endtask

  // Expansion written from the RVC encoding tables
  task automatic ref_expand(input logic [15:0] c, output logic [31:0] exp, output logic ill);
    logic [11:0] simm;
    logic [6:0]  uoff;
    logic [20:0] joff;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    simm = 12'($signed({c[12], c[6:2]}));
    uoff = {c[5], c[12:10], c[6], 2'b00};
    joff = 21'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0}));
    rdp  = 5'd8 + {2'b00, c[4:2]};
    rs1p = 5'd8 + {2'b00, c[9:7]};
    ill  = 1'b0;
    exp  = {16'h0, c};
    case ({c[15:13], c[1:0]})
      5'b010_00: exp = {5'd0, uoff, rs1p, 3'b010, rdp, 7'h03};
      5'b110_00: exp = {5'd0, uoff[6:5], rdp, rs1p, 3'b010, uoff[4:0], 7'h23};
      5'b000_01: exp = {simm, c[11:7], 3'b000, c[11:7], 7'h13};
      5'b010_01: exp = {simm, 5'd0, 3'b000, c[11:7], 7'h13};
      5'b101_01: exp = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6F};
      5'b100_10: begin
        if (c[6:2] == 5'd0) ill = 1'b1;
        else if (c[12]) exp = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], 7'h33};
        else exp = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], 7'h33};
      end
      default: ill = 1'b1;
    endcase
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("%s: done, %0d errors", name, errors - err_before);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_boot();
    int e0;
    e0 = errors;
    boot_addr_i <= 32'h0000_0102;
    redirect(PC_BOOT);
    check_words(32'h0000_0100, 8);
    end_test("boot", e0);
  endtask

  task automatic test_redirect();
    pc_mux_e muxes [7];
    int      e0;
    e0    = errors;
    muxes = '{PC_JUMP, PC_BRANCH, PC_MRET, PC_DRET, PC_TRAP_EXC, PC_TRAP_IRQ, PC_TRAP_DBD};
    jump_target_i   <= 32'h0000_0201;
    branch_target_i <= 32'h0000_0244;
    mepc_i          <= 32'h0000_0300;
    dpc_i           <= 32'h0000_0340;
    mtvec_addr_i    <= 25'h5;
    irq_id_i        <= 5'd3;
    dm_halt_addr_i  <= 32'h0000_03C3;
    for (int k = 0; k < 7; k++) begin
      redirect(muxes[k]);
      check_words(expected_target(muxes[k]), 2);
    end
    end_test("redirect", e0);
  endtask

  task automatic test_compressed();
    logic [15:0] hw [14];
    logic [31:0] pc;
    logic [31:0] exp;
    logic        ill;
    logic        ok;
    int          idx;
    int          e0;
    e0 = errors;
    // addi 32-bit at 0x802 crosses into the next word, 0x0506 is c.slli
    hw = '{16'h12F5, 16'h8093, 16'h0010, 16'h451D, 16'h4144, 16'hC60C, 16'hBFF5,
           16'h831E, 16'h931E, 16'h0506, 16'h0013, 16'h0000, 16'h0513, 16'h0010};
    for (int k = 0; k < 7; k++) begin
      mem0.mem[10'h200 + k] = {hw[2*k+1], hw[2*k]};
    end
    jump_target_i <= 32'h0000_0800;
    redirect(PC_JUMP);
    pc  = 32'h0000_0800;
    idx = 0;
    while (idx < 14) begin
      wait_instr(ok);
      if (!ok) break;
      check_val("id_pc_o", cap_pc, pc);
      if (hw[idx][1:0] == 2'b11) begin
        check_val("id_instr_o", cap_instr, {hw[idx+1], hw[idx]});
        check_val("id_compressed_o", 32'(cap_comp), 32'd0);
        pc  = pc + 32'd4;
        idx = idx + 2;
      end else begin
        ref_expand(hw[idx], exp, ill);
        check_val("id_instr_o", cap_instr, exp);
        check_val("id_compressed_o", 32'(cap_comp), 32'd1);
        check_val("id_illegal_c_o", 32'(cap_ill), 32'(ill));
        check_val("id_compressed_instr_o", 32'(cap_chw), 32'(hw[idx]));
        pc  = pc + 32'd2;
        idx = idx + 1;
      end
    end
    end_test("compressed", e0);
  endtask

  task automatic test_backpressure();
    logic [31:0] s_pc;
    logic [31:0] s_instr;
    logic [15:0] s_chw;
    logic        s_valid;
    logic        s_err;
    logic        s_comp;
    logic        s_ill;
    int          hold;
    int          e0;
    e0 = errors;
    jump_target_i <= 32'h0000_0400;
    redirect(PC_JUMP);
    check_words(32'h0000_0400, 2);
    id_ready_i <= 1'b0;
    hold = 3 + int'($unsigned($random(seed)) % 8);
    @(posedge clk);
    s_pc    = id_pc_o;
    s_instr = id_instr_o;
    s_valid = id_valid_o;
    s_err   = id_bus_err_o;
    s_comp  = id_compressed_o;
    s_ill   = id_illegal_c_o;
    s_chw   = id_compressed_instr_o;
    repeat (hold) begin
      @(posedge clk);
      check_val("id_valid_o", 32'(id_valid_o), 32'(s_valid));
      check_val("id_pc_o", id_pc_o, s_pc);
      check_val("id_instr_o", id_instr_o, s_instr);
      check_val("id_bus_err_o", 32'(id_bus_err_o), 32'(s_err));
      check_val("id_compressed_o", 32'(id_compressed_o), 32'(s_comp));
      check_val("id_illegal_c_o", 32'(id_illegal_c_o), 32'(s_ill));
      check_val("id_compressed_instr_o", 32'(id_compressed_instr_o), 32'(s_chw));
    end
    id_ready_i <= 1'b1;
    // Sequence picks up right after the last word taken
    check_words(32'h0000_0408, 4);
    end_test("backpressure", e0);
  endtask

  task automatic test_halt_err();
    logic [31:0] next;
    int          e0;
    e0 = errors;
    jump_target_i <= 32'h0000_05F8;
    redirect(PC_JUMP);
    check_words(32'h0000_05F8, 1);
    halt_if_i <= 1'b1;
    next = 32'h0000_05FC;
    // One word may already sit in ID when the halt lands
    @(posedge clk);
    if (id_valid_o && id_ready_i) begin
      check_val("id_pc_o", id_pc_o, next);
      next = next + 32'd4;
    end
    repeat (10) begin
      @(posedge clk);
      if (id_valid_o) begin
        $display("%0t: id_valid_o high while IF is halted", $time);
        errors++;
      end
    end
    halt_if_i <= 1'b0;
    // Covers the error address 0x600
    check_words(next, 4);
    end_test("halt_buserr", e0);
  endtask

  initial begin
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    boot_addr_i     = 32'h0;
    jump_target_i   = 32'h0;
    branch_target_i = 32'h0;
    mepc_i          = 32'h0;
    dpc_i           = 32'h0;
    dm_halt_addr_i  = 32'h0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_val("instr_req_o", 32'(instr_req_o), 32'd0);
    check_val("id_valid_o", 32'(id_valid_o), 32'd0);
    check_val("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'd0);
    test_boot();
    test_redirect();
    test_compressed();
    test_backpressure();
    test_halt_err();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tb_instr_mem.sv */
`timescale 1ns/100ps

module tb_instr_mem #(
  parameter logic [31:0] ERR_ADDR = 32'h0000_0600
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  localparam int MEM_WORDS = 1024;

  // Word array, index taken from address bits 11:2
  logic [31:0] mem [MEM_WORDS];
  // Cycles left before the pending request is granted
  logic [1:0]  wait_q;
  integer      seed;

  initial begin
    seed = 73;
    // Fill word carries the word index, low bits mark a 32-bit instruction
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[29:0], 2'b11};
    end
  end

  ////////////////////
  // Grant and response
  ////////////////////

  assign gnt_o = req_i && (wait_q == 2'd0);

  // One response per grant, always in the next cycle
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q   <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= 32'h0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= gnt_o;
      if (gnt_o) begin
        rdata_o <= mem[addr_i[11:2]];
        err_o   <= (addr_i == ERR_ADDR);
        // Next request waits 0 to 2 cycles
        wait_q  <= 2'($unsigned($random(seed)) % 3);
      end else if (req_i && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

endmodule
